//--- rtl/i2c_pkg.sv
`default_nettype none
/* Shared I2C master definitions: widths, register map, bit positions,
   reset values and the bit command type */
package i2c_pkg;

  localparam int byte_w = 8;
  localparam int prer_w = 16;

  // Wishbone register map
  localparam logic [2:0] adr_prer_lo = 3'd0;
  localparam logic [2:0] adr_prer_hi = 3'd1;
  localparam logic [2:0] adr_ctr     = 3'd2;
  localparam logic [2:0] adr_txr_rxr = 3'd3;
  localparam logic [2:0] adr_cr_sr   = 3'd4;

  localparam logic [prer_w-1:0] prer_reset = '1;

  // Control register
  localparam int ctr_en_bit  = 7;
  localparam int ctr_ien_bit = 6;
  localparam logic [byte_w-1:0] ctr_mask = 8'hC0;

  // Command register, write side of address 4
  localparam int cr_sta_bit  = 7;
  localparam int cr_sto_bit  = 6;
  localparam int cr_rd_bit   = 5;
  localparam int cr_wr_bit   = 4;
  localparam int cr_ack_bit  = 3;
  localparam int cr_iack_bit = 0;

  // Status register, read side of address 4
  localparam int sr_rxack_bit = 7;
  localparam int sr_busy_bit  = 6;
  localparam int sr_al_bit    = 5;
  localparam int sr_tip_bit   = 1;
  localparam int sr_if_bit    = 0;

  typedef enum logic [2:0] {
    bit_idle,
    bit_start,
    bit_stop,
    bit_write,
    bit_read
  } bit_cmd_t;

endpackage
`default_nettype wire

//--- rtl/i2c_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none
/* Byte command channel between register block and byte controller */
interface i2c_cmd_if;

  // One strobe per command, done comes back once
  logic                       cmd_stb;
  logic                       sta;
  logic                       sto;
  logic                       rd;
  logic                       wr;
  logic                       ack_out;
  logic [i2c_pkg::byte_w-1:0] txd;
  logic                       done;
  logic [i2c_pkg::byte_w-1:0] rxd;
  logic                       rxack;

  modport regs (output cmd_stb, sta, sto, rd, wr, ack_out, txd,
                input  done, rxd, rxack);

  modport byte_ctrl (input  cmd_stb, sta, sto, rd, wr, ack_out, txd,
                     output done, rxd, rxack);

endinterface
`default_nettype wire

//--- rtl/i2c_bit_if.sv
`timescale 1ns/1ps
`default_nettype none
/* Bit command channel between byte controller and bit controller */
interface i2c_bit_if;

  logic              bit_stb;
  i2c_pkg::bit_cmd_t cmd;
  logic              din;

  // dout holds the sampled SDA level when bit_done pulses
  logic              bit_done;
  logic              dout;
  logic              busy;

  modport byte_ctrl (output bit_stb, cmd, din,
                     input  bit_done, dout, busy);

  modport bit_ctrl (input  bit_stb, cmd, din,
                    output bit_done, dout, busy);

endinterface
`default_nettype wire

//--- rtl/i2c_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none
/* Wishbone slave with prescale, control, data, command and status registers
   and the interrupt output */
module i2c_wb_regs (
  input  wire                         wb_clk_i,
  input  wire                         arst_i,
  input  wire  [2:0]                  wb_adr_i,
  input  wire  [i2c_pkg::byte_w-1:0]  wb_dat_i,
  input  wire                         wb_we_i,
  input  wire                         wb_stb_i,
  input  wire                         wb_cyc_i,
  output logic                        wb_ack_o,
  output logic [i2c_pkg::byte_w-1:0]  wb_dat_o,
  output logic                        wb_inta_o,
  output logic [i2c_pkg::prer_w-1:0]  prer_o,
  output logic                        en_o,
  input  wire                         busy_i,
  i2c_cmd_if.regs                     cmd
);

  logic [i2c_pkg::prer_w-1:0] prer;
  logic [i2c_pkg::byte_w-1:0] ctr;
  logic [i2c_pkg::byte_w-1:0] txr;
  logic [i2c_pkg::byte_w-1:0] rxr;
  logic [i2c_pkg::byte_w-1:0] cr;
  logic [i2c_pkg::byte_w-1:0] cr_wdat;
  logic [i2c_pkg::byte_w-1:0] sr;
  logic                       tip;
  logic                       irq_flag;
  logic                       rxack;
  logic                       wb_req;
  logic                       wb_wacc;
  logic                       cmd_go;

  assign wb_req  = wb_stb_i & wb_cyc_i & ~wb_ack_o;
  assign wb_wacc = wb_req & wb_we_i;
  assign cmd_go  = cr[i2c_pkg::cr_sta_bit] | cr[i2c_pkg::cr_sto_bit] |
                   cr[i2c_pkg::cr_rd_bit] | cr[i2c_pkg::cr_wr_bit];
  assign prer_o  = prer;
  assign en_o    = ctr[i2c_pkg::ctr_en_bit];
  assign cmd.txd = txr;

  // Command bits only accepted when enabled and idle, IACK always
  always_comb begin
    cr_wdat = '0;
    cr_wdat[i2c_pkg::cr_iack_bit] = wb_dat_i[i2c_pkg::cr_iack_bit];
    if (ctr[i2c_pkg::ctr_en_bit] && !tip) begin
      cr_wdat[i2c_pkg::cr_sta_bit] = wb_dat_i[i2c_pkg::cr_sta_bit];
      cr_wdat[i2c_pkg::cr_sto_bit] = wb_dat_i[i2c_pkg::cr_sto_bit];
      cr_wdat[i2c_pkg::cr_rd_bit]  = wb_dat_i[i2c_pkg::cr_rd_bit];
      cr_wdat[i2c_pkg::cr_wr_bit]  = wb_dat_i[i2c_pkg::cr_wr_bit];
      cr_wdat[i2c_pkg::cr_ack_bit] = wb_dat_i[i2c_pkg::cr_ack_bit];
    end
  end

  always_comb begin
    sr = '0;
    sr[i2c_pkg::sr_rxack_bit] = rxack;
    sr[i2c_pkg::sr_busy_bit]  = busy_i;
    sr[i2c_pkg::sr_al_bit]    = 1'b0;
    sr[i2c_pkg::sr_tip_bit]   = tip;
    sr[i2c_pkg::sr_if_bit]    = irq_flag;
  end

  always_ff @(posedge wb_clk_i) begin
    case (wb_adr_i)
      i2c_pkg::adr_prer_lo: wb_dat_o <= prer[i2c_pkg::byte_w-1:0];
      i2c_pkg::adr_prer_hi: wb_dat_o <= prer[i2c_pkg::prer_w-1:i2c_pkg::byte_w];
      i2c_pkg::adr_ctr:     wb_dat_o <= ctr;
      i2c_pkg::adr_txr_rxr: wb_dat_o <= rxr;
      i2c_pkg::adr_cr_sr:   wb_dat_o <= sr;
      default:              wb_dat_o <= '0;
    endcase
    if (wb_wacc && wb_adr_i == i2c_pkg::adr_txr_rxr && !tip) begin
      txr <= wb_dat_i;
    end
    if (cmd_go) begin
      cmd.sta     <= cr[i2c_pkg::cr_sta_bit];
      cmd.sto     <= cr[i2c_pkg::cr_sto_bit];
      cmd.rd      <= cr[i2c_pkg::cr_rd_bit];
      cmd.wr      <= cr[i2c_pkg::cr_wr_bit];
      cmd.ack_out <= cr[i2c_pkg::cr_ack_bit];
    end
    if (cmd.done) begin
      rxr <= cmd.rxd;
    end
  end

  always_ff @(posedge wb_clk_i or posedge arst_i) begin
    if (arst_i) begin
      wb_ack_o <= 1'b0;
      prer     <= i2c_pkg::prer_reset;
      ctr      <= '0;
      cr       <= '0;
    end else begin
      wb_ack_o <= wb_req;
      // Command bits clear themselves after one cycle
      cr <= (wb_wacc && wb_adr_i == i2c_pkg::adr_cr_sr) ? cr_wdat : '0;
      if (wb_wacc) begin
        case (wb_adr_i)
          i2c_pkg::adr_prer_lo:
            if (!en_o) prer[i2c_pkg::byte_w-1:0] <= wb_dat_i;
          i2c_pkg::adr_prer_hi:
            if (!en_o) prer[i2c_pkg::prer_w-1:i2c_pkg::byte_w] <= wb_dat_i;
          i2c_pkg::adr_ctr:
            ctr <= wb_dat_i & i2c_pkg::ctr_mask;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge wb_clk_i or posedge arst_i) begin
    if (arst_i) begin
      cmd.cmd_stb <= 1'b0;
      tip         <= 1'b0;
      irq_flag    <= 1'b0;
      rxack       <= 1'b0;
      wb_inta_o   <= 1'b0;
    end else begin
      cmd.cmd_stb <= cmd_go;
      if (cmd_go) begin
        tip <= 1'b1;
      end else if (cmd.done || !en_o) begin
        tip <= 1'b0;
      end
      irq_flag <= (irq_flag | cmd.done) & ~cr[i2c_pkg::cr_iack_bit];
      if (cmd.done) begin
        rxack <= cmd.rxack;
      end
      wb_inta_o <= irq_flag & ctr[i2c_pkg::ctr_ien_bit];
    end
  end

  a_ack_single: assert property (@(posedge wb_clk_i) disable iff (arst_i)
    wb_req |=> wb_ack_o ##1 !wb_ack_o);

  a_cr_clear: assert property (@(posedge wb_clk_i) disable iff (arst_i)
    (wb_ack_o && wb_we_i && wb_adr_i == i2c_pkg::adr_cr_sr) |=> (cr == '0));

  // TIP rises exactly with the command strobe
  a_tip_stb: assert property (@(posedge wb_clk_i) disable iff (arst_i)
    $rose(tip) == cmd.cmd_stb);

endmodule
`default_nettype wire

//--- rtl/i2c_byte_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
/* Byte sequencer, splits byte commands into start, data, ack and stop bits */
module i2c_byte_ctrl (
  input  wire          wb_clk_i,
  input  wire          arst_i,
  input  wire          en_i,
  i2c_cmd_if.byte_ctrl cmd,
  i2c_bit_if.byte_ctrl bus
);

  typedef enum logic [2:0] {st_idle, st_start, st_data, st_ack, st_stop} state_t;

  state_t                     state;
  state_t                     state_n;
  logic [i2c_pkg::byte_w-1:0] sreg;
  logic [2:0]                 cnt;
  logic                       sto_q;
  logic                       rd_q;
  logic                       wr_q;
  logic                       ack_q;
  logic                       issue;
  i2c_pkg::bit_cmd_t          issue_cmd;
  logic                       issue_din;
  logic                       fin;

  assign cmd.rxd = sreg;

  always_comb begin
    state_n   = state;
    issue     = 1'b0;
    issue_cmd = i2c_pkg::bit_idle;
    issue_din = sreg[i2c_pkg::byte_w-1];
    fin       = 1'b0;
    case (state)
      st_idle: if (cmd.cmd_stb) begin
        issue = 1'b1;
        if (cmd.sta) begin
          state_n   = st_start;
          issue_cmd = i2c_pkg::bit_start;
        end else if (cmd.rd || cmd.wr) begin
          state_n   = st_data;
          issue_cmd = cmd.rd ? i2c_pkg::bit_read : i2c_pkg::bit_write;
          issue_din = cmd.txd[i2c_pkg::byte_w-1];
        end else begin
          state_n   = st_stop;
          issue_cmd = i2c_pkg::bit_stop;
        end
      end
      st_start: if (bus.bit_done) begin
        if (rd_q || wr_q) begin
          state_n   = st_data;
          issue     = 1'b1;
          issue_cmd = rd_q ? i2c_pkg::bit_read : i2c_pkg::bit_write;
        end else if (sto_q) begin
          state_n   = st_stop;
          issue     = 1'b1;
          issue_cmd = i2c_pkg::bit_stop;
        end else begin
          state_n = st_idle;
          fin     = 1'b1;
        end
      end
      st_data: if (bus.bit_done) begin
        issue = 1'b1;
        if (cnt == 3'd7) begin
          // Master acks a read, slave acks a write
          state_n   = st_ack;
          issue_cmd = rd_q ? i2c_pkg::bit_write : i2c_pkg::bit_read;
          issue_din = ack_q;
        end else begin
          issue_cmd = rd_q ? i2c_pkg::bit_read : i2c_pkg::bit_write;
          issue_din = sreg[i2c_pkg::byte_w-2];
        end
      end
      st_ack: if (bus.bit_done) begin
        if (sto_q) begin
          state_n   = st_stop;
          issue     = 1'b1;
          issue_cmd = i2c_pkg::bit_stop;
        end else begin
          state_n = st_idle;
          fin     = 1'b1;
        end
      end
      st_stop: if (bus.bit_done) begin
        state_n = st_idle;
        fin     = 1'b1;
      end
      default: state_n = st_idle;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (issue) begin
      bus.cmd <= issue_cmd;
      bus.din <= issue_din;
    end
    if (state == st_idle && cmd.cmd_stb) begin
      sreg  <= cmd.txd;
      sto_q <= cmd.sto;
      rd_q  <= cmd.rd;
      wr_q  <= cmd.wr;
      ack_q <= cmd.ack_out;
    end else if (state == st_data && bus.bit_done) begin
      // MSB first, sampled bits enter at the bottom
      sreg <= {sreg[i2c_pkg::byte_w-2:0], bus.dout};
    end
  end

  always_ff @(posedge wb_clk_i or posedge arst_i) begin
    if (arst_i) begin
      state       <= st_idle;
      bus.bit_stb <= 1'b0;
      cmd.done    <= 1'b0;
      cmd.rxack   <= 1'b0;
      cnt         <= '0;
    end else if (!en_i) begin
      state       <= st_idle;
      bus.bit_stb <= 1'b0;
      cmd.done    <= 1'b0;
      cnt         <= '0;
    end else begin
      state       <= state_n;
      bus.bit_stb <= issue;
      cmd.done    <= fin;
      if (state == st_data && bus.bit_done) begin
        cnt <= cnt + 3'd1;
      end
      if (state == st_ack && bus.bit_done) begin
        cmd.rxack <= bus.dout;
      end
    end
  end

  a_no_idle_bit: assert property (@(posedge wb_clk_i) disable iff (arst_i)
    bus.bit_stb |-> (state != st_idle));

endmodule
`default_nettype wire

//--- rtl/i2c_bit_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
/* Prescaled four-phase bit engine driving the SCL and SDA pad enables */
module i2c_bit_ctrl (
  input  wire                         wb_clk_i,
  input  wire                         arst_i,
  input  wire  [i2c_pkg::prer_w-1:0]  prer_i,
  input  wire                         en_i,
  i2c_bit_if.bit_ctrl                 bus,
  input  wire                         scl_pad_i,
  input  wire                         sda_pad_i,
  output logic                        scl_padoen_o,
  output logic                        sda_padoen_o
);

  i2c_pkg::bit_cmd_t          op;
  i2c_pkg::bit_cmd_t          op_n;
  logic [1:0]                 phase;
  logic [1:0]                 phase_n;
  logic [i2c_pkg::prer_w-1:0] cnt;
  logic [i2c_pkg::prer_w-1:0] cnt_n;
  logic                       fin;
  logic                       scl_n;
  logic                       sda_n;
  logic                       din_q;

  always_comb begin
    op_n    = op;
    phase_n = phase;
    cnt_n   = cnt;
    fin     = 1'b0;
    if (bus.bit_stb) begin
      op_n    = bus.cmd;
      phase_n = 2'd0;
      cnt_n   = prer_i;
    end else if (op != i2c_pkg::bit_idle) begin
      if (cnt == '0) begin
        cnt_n = prer_i;
        if (phase == 2'd3) begin
          op_n = i2c_pkg::bit_idle;
          fin  = 1'b1;
        end else begin
          phase_n = phase + 2'd1;
        end
      end else begin
        cnt_n = cnt - 1'b1;
      end
    end

    // Pad enables for the upcoming phase, held while idle
    scl_n = scl_padoen_o;
    sda_n = sda_padoen_o;
    case (op_n)
      i2c_pkg::bit_start: case (phase_n)
        2'd0: sda_n = 1'b1;
        2'd1: scl_n = 1'b1;
        2'd2: sda_n = 1'b0;
        default: scl_n = 1'b0;
      endcase
      i2c_pkg::bit_stop: case (phase_n)
        2'd0: scl_n = 1'b0;
        2'd1: sda_n = 1'b0;
        2'd2: scl_n = 1'b1;
        default: sda_n = 1'b1;
      endcase
      i2c_pkg::bit_write, i2c_pkg::bit_read: case (phase_n)
        2'd0: scl_n = 1'b0;
        2'd1: sda_n = (op_n == i2c_pkg::bit_write) ? din_q : 1'b1;
        2'd2: scl_n = 1'b1;
        default: scl_n = 1'b0;
      endcase
      default: ;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (bus.bit_stb) begin
      din_q <= bus.din;
    end
    // Sample while SCL is seen high in the third phase
    if ((op == i2c_pkg::bit_read || op == i2c_pkg::bit_write) &&
        phase == 2'd2 && scl_pad_i) begin
      bus.dout <= sda_pad_i;
    end
  end

  always_ff @(posedge wb_clk_i or posedge arst_i) begin
    if (arst_i) begin
      op           <= i2c_pkg::bit_idle;
      phase        <= 2'd0;
      cnt          <= '0;
      bus.bit_done <= 1'b0;
      bus.busy     <= 1'b0;
      scl_padoen_o <= 1'b1;
      sda_padoen_o <= 1'b1;
    end else if (!en_i) begin
      op           <= i2c_pkg::bit_idle;
      phase        <= 2'd0;
      cnt          <= '0;
      bus.bit_done <= 1'b0;
      bus.busy     <= 1'b0;
      scl_padoen_o <= 1'b1;
      sda_padoen_o <= 1'b1;
    end else begin
      op           <= op_n;
      phase        <= phase_n;
      cnt          <= cnt_n;
      bus.bit_done <= fin;
      scl_padoen_o <= scl_n;
      sda_padoen_o <= sda_n;
      if (bus.bit_stb && bus.cmd == i2c_pkg::bit_start) begin
        bus.busy <= 1'b1;
      end else if (fin && op == i2c_pkg::bit_stop) begin
        bus.busy <= 1'b0;
      end
    end
  end

  a_sda_stable: assert property (@(posedge wb_clk_i) disable iff (arst_i || !en_i)
    ($changed(sda_padoen_o) && scl_padoen_o && $past(scl_padoen_o))
    |-> ($past(op_n) inside {i2c_pkg::bit_start, i2c_pkg::bit_stop}));

endmodule
`default_nettype wire

//--- rtl/i2c_master_top.sv
`timescale 1ns/1ps
`default_nettype none
/* I2C master top level, register block plus byte and bit controllers */
module i2c_master_top (
  input  wire                         wb_clk_i,
  input  wire                         arst_i,
  input  wire  [2:0]                  wb_adr_i,
  input  wire  [i2c_pkg::byte_w-1:0]  wb_dat_i,
  output wire  [i2c_pkg::byte_w-1:0]  wb_dat_o,
  input  wire                         wb_we_i,
  input  wire                         wb_stb_i,
  input  wire                         wb_cyc_i,
  output wire                         wb_ack_o,
  output wire                         wb_inta_o,
  input  wire                         scl_pad_i,
  output wire                         scl_pad_o,
  output wire                         scl_padoen_o,
  input  wire                         sda_pad_i,
  output wire                         sda_pad_o,
  output wire                         sda_padoen_o
);

  wire [i2c_pkg::prer_w-1:0] prer;
  wire                       en;

  i2c_cmd_if cmd_bus ();
  i2c_bit_if bit_bus ();

  // Open-drain pads, only the enables toggle
  assign scl_pad_o = 1'b0;
  assign sda_pad_o = 1'b0;

  i2c_wb_regs i2c_wb_regs_inst (
    .wb_clk_i (wb_clk_i),
    .arst_i   (arst_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_we_i  (wb_we_i),
    .wb_stb_i (wb_stb_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_ack_o (wb_ack_o),
    .wb_dat_o (wb_dat_o),
    .wb_inta_o(wb_inta_o),
    .prer_o   (prer),
    .en_o     (en),
    .busy_i   (bit_bus.busy),
    .cmd      (cmd_bus.regs)
  );

  i2c_byte_ctrl i2c_byte_ctrl_inst (
    .wb_clk_i(wb_clk_i),
    .arst_i  (arst_i),
    .en_i    (en),
    .cmd     (cmd_bus.byte_ctrl),
    .bus     (bit_bus.byte_ctrl)
  );

  i2c_bit_ctrl i2c_bit_ctrl_inst (
    .wb_clk_i    (wb_clk_i),
    .arst_i      (arst_i),
    .prer_i      (prer),
    .en_i        (en),
    .bus         (bit_bus.bit_ctrl),
    .scl_pad_i   (scl_pad_i),
    .sda_pad_i   (sda_pad_i),
    .scl_padoen_o(scl_padoen_o),
    .sda_padoen_o(sda_padoen_o)
  );

endmodule
`default_nettype wire

//--- test/i2c_slave_model.sv
`timescale 1ns/1ps
`default_nettype none
/* Behavioral I2C slave, START/STOP detection, byte capture, ACK and read data */
module i2c_slave_model (
  input  wire        arst_i,
  input  wire        scl_i,
  input  wire        sda_i,
  input  wire        read_mode_i,
  output logic       sda_low_o,
  output int         start_cnt_o,
  output int         stop_cnt_o,
  output logic [7:0] byte_o,
  output logic       master_ack_o
);

  logic       scl_q;
  logic       sda_q;
  logic       active;
  logic       nacked;
  logic [3:0] bitcnt;
  logic [7:0] shift;

  // Edges found against the last seen line levels
  always @(posedge scl_i or negedge scl_i or posedge sda_i or negedge sda_i
           or posedge arst_i) begin
    if (arst_i) begin
      sda_low_o    = 1'b0;
      start_cnt_o  = 0;
      stop_cnt_o   = 0;
      byte_o       = 8'h00;
      master_ack_o = 1'b0;
      active       = 1'b0;
      nacked       = 1'b0;
      bitcnt       = 4'd0;
      shift        = 8'h00;
    end else if (scl_i && scl_q && sda_q && !sda_i) begin
      // START
      start_cnt_o = start_cnt_o + 1;
      active      = 1'b1;
      nacked      = 1'b0;
      bitcnt      = 4'd0;
      sda_low_o   = 1'b0;
    end else if (scl_i && scl_q && !sda_q && sda_i) begin
      stop_cnt_o = stop_cnt_o + 1;
      active     = 1'b0;
      sda_low_o  = 1'b0;
    end else if (active && scl_i && !scl_q) begin
      if (bitcnt == 4'd8) begin
        // Ninth clock carries the ACK bit
        if (read_mode_i) begin
          master_ack_o = sda_i;
          nacked       = sda_i;
        end
        bitcnt = 4'd0;
      end else begin
        shift = {shift[6:0], sda_i};
        if (bitcnt == 4'd7 && !read_mode_i) begin
          byte_o = shift;
        end
        bitcnt = bitcnt + 4'd1;
      end
    end else if (active && !scl_i && scl_q) begin
      if (bitcnt == 4'd8) begin
        sda_low_o = !read_mode_i && byte_o != 8'hFF;
      end else begin
        // Read data is the inverse of the last captured byte
        sda_low_o = read_mode_i && !nacked && byte_o[3'd7 - bitcnt[2:0]];
      end
    end
    scl_q = scl_i;
    sda_q = sda_i;
  end

endmodule
`default_nettype wire

//--- test/tb_i2c_master.sv
`timescale 1ns/1ps
`default_nettype none
/* I2C master testbench with Wishbone bus tasks, a slave model on
   wired-AND SCL and SDA lines, and the checks */
module tb_i2c_master;

  localparam int timeout_cycles = 3000;

  logic       wb_clk_i;
  logic       arst_i;
  logic [2:0] wb_adr_i;
  logic [7:0] wb_dat_i;
  logic       wb_we_i;
  logic       wb_stb_i;
  logic       wb_cyc_i;
  wire  [7:0] wb_dat_o;
  wire        wb_ack_o;
  wire        wb_inta_o;
  wire        scl_pad_o;
  wire        scl_padoen_o;
  wire        sda_pad_o;
  wire        sda_padoen_o;
  wire        scl_line;
  wire        sda_line;
  wire        sda_slave_low;
  logic       read_mode;
  int         start_cnt;
  int         stop_cnt;
  logic [7:0] slave_byte;
  logic       master_ack;
  int         errors;
  int         checks;
  int         tests;
  int         test_base;
  int         seed;
  int         rnd;
  logic [7:0] tx;
  logic [7:0] rd;

  // Pulled-up lines that either side can pull low
  assign scl_line = scl_padoen_o | scl_pad_o;
  assign sda_line = (sda_padoen_o | sda_pad_o) & ~sda_slave_low;

  i2c_master_top i2c_master_top_inst (
    .wb_clk_i    (wb_clk_i),
    .arst_i      (arst_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_we_i     (wb_we_i),
    .wb_stb_i    (wb_stb_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_ack_o    (wb_ack_o),
    .wb_inta_o   (wb_inta_o),
    .scl_pad_i   (scl_line),
    .scl_pad_o   (scl_pad_o),
    .scl_padoen_o(scl_padoen_o),
    .sda_pad_i   (sda_line),
    .sda_pad_o   (sda_pad_o),
    .sda_padoen_o(sda_padoen_o)
  );

  i2c_slave_model i2c_slave_model_inst (
    .arst_i      (arst_i),
    .scl_i       (scl_line),
    .sda_i       (sda_line),
    .read_mode_i (read_mode),
    .sda_low_o   (sda_slave_low),
    .start_cnt_o (start_cnt),
    .stop_cnt_o  (stop_cnt),
    .byte_o      (slave_byte),
    .master_ack_o(master_ack)
  );

  always #50 wb_clk_i = ~wb_clk_i;

  task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    checks++;
    assert (cond) else begin
      $display("Check failed: %s", what);
      errors++;
    end
  endtask

  // One classic cycle with the ack due one cycle after the request
  task automatic wb_xfer(input logic [2:0] adr, input logic we, input logic [7:0] wdat,
                         output logic [7:0] rdat);
    int lat;
    @(posedge wb_clk_i);
    wb_adr_i <= adr;
    wb_dat_i <= wdat;
    wb_we_i  <= we;
    wb_stb_i <= 1'b1;
    wb_cyc_i <= 1'b1;
    lat = 0;
    do begin
      @(negedge wb_clk_i);
      lat++;
    end while (!wb_ack_o && lat < timeout_cycles);
    rdat = wb_dat_o;
    check_true("wishbone ack one cycle after the request", wb_ack_o && lat == 2);
    @(posedge wb_clk_i);
    wb_stb_i <= 1'b0;
    wb_cyc_i <= 1'b0;
    wb_we_i  <= 1'b0;
    @(negedge wb_clk_i);
    check_true("wishbone ack lasts one cycle", !wb_ack_o);
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [7:0] wdat);
    logic [7:0] rdat;
    wb_xfer(adr, 1'b1, wdat, rdat);
  endtask

  task automatic wb_read(input logic [2:0] adr, output logic [7:0] rdat);
    wb_xfer(adr, 1'b0, 8'h00, rdat);
  endtask

  // Poll SR until TIP clears
  task automatic wait_transfer(output logic [7:0] sr);
    int n;
    n = 0;
    do begin
      wb_read(i2c_pkg::adr_cr_sr, sr);
      n++;
    end while (sr[i2c_pkg::sr_tip_bit] && n < timeout_cycles);
    check_true("transfer finished before the timeout", !sr[i2c_pkg::sr_tip_bit]);
    check_true("IF set when the transfer finished", sr[i2c_pkg::sr_if_bit]);
  endtask

  // START, byte write, STOP
  task automatic write_byte(input logic [7:0] data);
    int         starts;
    int         stops;
    logic [7:0] sr;
    starts = start_cnt;
    stops  = stop_cnt;
    wb_write(i2c_pkg::adr_txr_rxr, data);
    wb_write(i2c_pkg::adr_cr_sr, 8'hD0);
    wb_read(i2c_pkg::adr_cr_sr, sr);
    check_true("TIP set after the command write", sr[i2c_pkg::sr_tip_bit]);
    wait_transfer(sr);
    check_val("slave_byte", slave_byte, data);
    check_true("slave saw one start", start_cnt == starts + 1);
    check_true("slave saw one stop", stop_cnt == stops + 1);
    // Slave leaves FF unacknowledged
    check_val("sr", sr, {data == 8'hFF, 6'b000000, 1'b1});
  endtask

  task automatic wait_inta(input logic level, input string what);
    int n;
    n = 0;
    while (wb_inta_o !== level && n < timeout_cycles) begin
      @(negedge wb_clk_i);
      n++;
    end
    check_true(what, wb_inta_o === level);
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_base) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, errors - test_base);
    end
    test_base = errors;
  endtask

  initial begin
    wb_clk_i  = 1'b0;
    arst_i    = 1'b1;
    wb_adr_i  = 3'd0;
    wb_dat_i  = 8'h00;
    wb_we_i   = 1'b0;
    wb_stb_i  = 1'b0;
    wb_cyc_i  = 1'b0;
    read_mode = 1'b0;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    test_base = 0;
    seed      = 32'h8af5184d;
    repeat (2) @(posedge wb_clk_i);
    arst_i <= 1'b0;

    wb_read(i2c_pkg::adr_prer_lo, rd);
    check_val("prer_lo", rd, 8'hFF);
    wb_read(i2c_pkg::adr_prer_hi, rd);
    check_val("prer_hi", rd, 8'hFF);
    wb_read(i2c_pkg::adr_ctr, rd);
    check_val("ctr", rd, 8'h00);
    wb_read(i2c_pkg::adr_cr_sr, rd);
    check_val("sr", rd, 8'h00);
    check_val("wb_inta_o", {7'd0, wb_inta_o}, 8'h00);
    check_val("scl_padoen_o", {7'd0, scl_padoen_o}, 8'h01);
    check_val("sda_padoen_o", {7'd0, sda_padoen_o}, 8'h01);
    check_val("scl_pad_o", {7'd0, scl_pad_o}, 8'h00);
    check_val("sda_pad_o", {7'd0, sda_pad_o}, 8'h00);
    end_test("reset and bus timing");

    wb_write(i2c_pkg::adr_prer_lo, 8'h03);
    wb_write(i2c_pkg::adr_prer_hi, 8'h00);
    wb_read(i2c_pkg::adr_prer_lo, rd);
    check_val("prer_lo", rd, 8'h03);
    wb_read(i2c_pkg::adr_prer_hi, rd);
    check_val("prer_hi", rd, 8'h00);
    wb_write(i2c_pkg::adr_ctr, 8'hFF);
    wb_read(i2c_pkg::adr_ctr, rd);
    check_val("ctr", rd, 8'hC0);
    // Prescaler locked while EN is set
    wb_write(i2c_pkg::adr_prer_lo, 8'h5A);
    wb_read(i2c_pkg::adr_prer_lo, rd);
    check_val("prer_lo", rd, 8'h03);
    wb_write(i2c_pkg::adr_ctr, 8'h80);
    wb_read(i2c_pkg::adr_ctr, rd);
    check_val("ctr", rd, 8'h80);
    end_test("register access");

    write_byte(8'hFF);
    wb_write(i2c_pkg::adr_cr_sr, 8'h01);
    rnd = $random(seed);
    tx  = rnd[7:0];
    write_byte(tx);
    wb_write(i2c_pkg::adr_cr_sr, 8'h01);
    end_test("write byte with start and stop");

    @(posedge wb_clk_i);
    read_mode <= 1'b1;
    wb_write(i2c_pkg::adr_cr_sr, 8'hE8);
    wait_transfer(rd);
    wb_read(i2c_pkg::adr_txr_rxr, rd);
    check_val("rxr", rd, ~tx);
    check_val("master_ack", {7'd0, master_ack}, 8'h01);
    @(posedge wb_clk_i);
    read_mode <= 1'b0;
    wb_write(i2c_pkg::adr_cr_sr, 8'h01);
    end_test("read byte");

    wb_write(i2c_pkg::adr_ctr, 8'hC0);
    rnd = $random(seed);
    write_byte(rnd[7:0]);
    wait_inta(1'b1, "wb_inta_o rises after the transfer with IEN set");
    wb_write(i2c_pkg::adr_cr_sr, 8'h01);
    wait_inta(1'b0, "wb_inta_o falls after IACK");
    wb_read(i2c_pkg::adr_cr_sr, rd);
    check_true("IF cleared by IACK", !rd[i2c_pkg::sr_if_bit]);
    wb_write(i2c_pkg::adr_ctr, 8'h80);
    rnd = $random(seed);
    write_byte(rnd[7:0]);
    repeat (4) begin
      @(negedge wb_clk_i);
      check_val("wb_inta_o", {7'd0, wb_inta_o}, 8'h00);
    end
    end_test("interrupt");

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
`default_nettype wire

//--- vlog.f
rtl/i2c_pkg.sv
rtl/i2c_cmd_if.sv
rtl/i2c_bit_if.sv
rtl/i2c_wb_regs.sv
rtl/i2c_byte_ctrl.sv
rtl/i2c_bit_ctrl.sv
rtl/i2c_master_top.sv
test/i2c_slave_model.sv
test/tb_i2c_master.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the I2C master testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_i2c_master -f vlog.f \
  && ./obj_dir/Vtb_i2c_master 2>&1 | tee sim.log \
  || { echo "build or simulation failed"; exit 1; }
grep -qx "Finished with no errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
